/* list.f */
source/net_types_pkg.sv
source/echo_config_pkg.sv
source/echo_header_queue.sv
source/echo_payload_fifo.sv
source/echo_frame_merger.sv
source/udp_echo_core.sv
sim/udp_echo_core_tb.sv

/* Makefile */
# Verilator build and run of the UDP echo engine testbench

TOP = udp_echo_core_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build output"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f list.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Simulation completed successfully"

clean:
	rm -rf obj_dir

/* sim/udp_echo_patterns.txt */
// source_ip dest_ip source_port dest_port length beat_count, one frame per line, hex
// dest_port 04d2 (1234) is echoed, any other port is dropped
c0a80105 c0a80180 c350 04d2 0020 00000003
c0a80106 c0a80180 d000 0035 0018 00000002
c0a80107 c0a80180 1f90 04d2 0048 00000008
c0a80108 c0a80180 04d2 04d3 0010 00000001
0a000001 c0a80180 ea60 04d2 0058 0000000a
0a000002 c0a80180 1388 0050 0028 00000004
c0a80109 c0a80180 0045 04d2 0010 00000001
// Burst of short frames sent back to back
c0a8010a c0a80180 8001 04d2 0010 00000001
c0a8010b c0a80180 8002 04d2 0018 00000002
c0a8010c c0a80180 8003 04d2 0010 00000001
c0a8010d c0a80180 8004 1234 0010 00000001
c0a8010e c0a80180 8005 04d2 0018 00000002
c0a8010f c0a80180 8006 04d2 0010 00000001
c0a80110 c0a80180 8007 04d2 0018 00000002

/* sim/udp_echo_core_tb.sv */
// ------------------------------
// Testbench of the UDP echo engine
// Frames come from the pattern file, replies are
// checked against headers and beats built here
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module udp_echo_core_tb;

    localparam logic [31:0] SEED          = 32'h6049_4029;
    localparam int          N_FRAMES      = 14;
    localparam int          TIMEOUT       = 2000;
    // Reply rules of the echo engine
    localparam logic [15:0] ECHO_PORT_EXP = 16'd1234;
    localparam logic [31:0] LOCAL_IP_EXP  = 32'hC0A8_0180;
    localparam logic [7:0]  TTL_EXP       = 8'd64;

    logic                         clk = 1'b0;
    logic                         rst;
    net_types_pkg::udp_rx_hdr_t   rx_hdr;
    logic                         rx_hdr_valid;
    logic                         rx_hdr_ready;
    net_types_pkg::payload_beat_t rx_payload;
    logic                         rx_payload_valid;
    logic                         rx_payload_ready;
    net_types_pkg::udp_tx_hdr_t   tx_hdr;
    logic                         tx_hdr_valid;
    logic                         tx_hdr_ready = 1'b0;
    net_types_pkg::payload_beat_t tx_payload;
    logic                         tx_payload_valid;
    logic                         tx_payload_ready = 1'b0;
    logic [7:0]                   led;

    logic [31:0]                  pat_mem [N_FRAMES*6];
    net_types_pkg::udp_tx_hdr_t   exp_hdr_q [$];
    net_types_pkg::payload_beat_t exp_beat_q [$];
    net_types_pkg::udp_tx_hdr_t   exp_hdr;
    net_types_pkg::payload_beat_t exp_beat;
    net_types_pkg::udp_tx_hdr_t   hdr_held;
    net_types_pkg::payload_beat_t beat_held;
    logic [31:0]                  data_state = SEED;
    logic [31:0]                  gap_state = ~SEED;
    logic [7:0]                   led_expect = 8'h00;
    logic                         first_pending = 1'b0;
    logic                         hdr_pending = 1'b0;
    logic                         beat_pending = 1'b0;
    int                           errors = 0;
    int                           checks = 0;

    udp_echo_core UUT (.*);

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Random ready gaps on both transmit outputs
    always @(posedge clk) begin
        #1;
        gap_state = xorshift32(gap_state);
        tx_hdr_ready     = (gap_state[1:0] != 2'b00);
        tx_payload_ready = (gap_state[9:8] != 2'b00);
    end

    // Called just after a rising edge, returns just after the transfer edge
    task automatic send_header(input net_types_pkg::udp_rx_hdr_t h);
        int waited;
        waited = 0;
        rx_hdr       = h;
        rx_hdr_valid = 1'b1;
        @(negedge clk);
        while (!rx_hdr_ready && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        assert (rx_hdr_ready) else begin
            errors++;
            $display("Timed out waiting for rx_hdr_ready");
        end
        @(posedge clk);
        #1;
        rx_hdr_valid = 1'b0;
    endtask

    task automatic send_beat(input net_types_pkg::payload_beat_t b);
        int waited;
        waited = 0;
        rx_payload       = b;
        rx_payload_valid = 1'b1;
        @(negedge clk);
        while (!rx_payload_ready && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        assert (rx_payload_ready) else begin
            errors++;
            $display("Timed out waiting for rx_payload_ready");
        end
        @(posedge clk);
        #1;
        rx_payload_valid = 1'b0;
    endtask

    task automatic drive_headers();
        net_types_pkg::udp_rx_hdr_t h;
        net_types_pkg::udp_tx_hdr_t r;
        for (int i = 0; i < N_FRAMES; i++) begin
            h.source_ip   = pat_mem[6*i];
            h.dest_ip     = pat_mem[6*i+1];
            h.source_port = pat_mem[6*i+2][15:0];
            h.dest_port   = pat_mem[6*i+3][15:0];
            h.length      = pat_mem[6*i+4][15:0];
            // Reply goes to the sender with ports swapped
            r.source_ip   = LOCAL_IP_EXP;
            r.dest_ip     = h.source_ip;
            r.source_port = h.dest_port;
            r.dest_port   = h.source_port;
            r.length      = h.length;
            r.ttl         = TTL_EXP;
            r.checksum    = 16'h0000;
            if (h.dest_port == ECHO_PORT_EXP) begin
                exp_hdr_q.push_back(r);
            end
            send_header(h);
        end
    endtask

    task automatic drive_payloads();
        net_types_pkg::payload_beat_t b;
        int                           beats;
        logic                         echoed;
        for (int i = 0; i < N_FRAMES; i++) begin
            beats  = int'(pat_mem[6*i+5]);
            echoed = (pat_mem[6*i+3][15:0] == ECHO_PORT_EXP);
            for (int k = 0; k < beats; k++) begin
                data_state    = xorshift32(data_state);
                b.data[31:0]  = data_state;
                data_state    = xorshift32(data_state);
                b.data[63:32] = data_state;
                b.last        = (k == beats - 1);
                // Partial keep and error flag only on the last beat
                data_state    = xorshift32(data_state);
                b.keep        = b.last ? (8'hFF >> data_state[2:0]) : 8'hFF;
                b.user        = b.last && data_state[3];
                if (echoed) begin
                    exp_beat_q.push_back(b);
                end
                send_beat(b);
            end
        end
    endtask

    // Outputs settle after the rising edge, so sample at the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            checks++;
            assert (led == led_expect) else begin
                errors++;
                $display("[FAIL] led expected %h got %h", led_expect, led);
            end
            if (hdr_pending) begin
                assert (tx_hdr_valid && tx_hdr == hdr_held) else begin
                    errors++;
                    $display("Header output dropped or changed before its transfer");
                end
            end
            if (beat_pending) begin
                assert (tx_payload_valid && tx_payload == beat_held) else begin
                    errors++;
                    $display("Payload output dropped or changed before its transfer");
                end
            end
            hdr_pending  = tx_hdr_valid && !tx_hdr_ready;
            hdr_held     = tx_hdr;
            beat_pending = tx_payload_valid && !tx_payload_ready;
            beat_held    = tx_payload;

            if (tx_hdr_valid && tx_hdr_ready) begin
                assert (exp_hdr_q.size() != 0) else begin
                    errors++;
                    $display("Header sent when no echoed frame was expected");
                end
                if (exp_hdr_q.size() != 0) begin
                    exp_hdr = exp_hdr_q.pop_front();
                    checks++;
                    assert (tx_hdr == exp_hdr) else begin
                        errors++;
                        $display("[FAIL] tx_hdr expected %h got %h", exp_hdr, tx_hdr);
                    end
                end
                first_pending = 1'b1;
            end

            if (tx_payload_valid && tx_payload_ready) begin
                assert (exp_beat_q.size() != 0) else begin
                    errors++;
                    $display("Payload beat sent when none was expected");
                end
                if (exp_beat_q.size() != 0) begin
                    exp_beat = exp_beat_q.pop_front();
                    checks++;
                    assert (tx_payload == exp_beat) else begin
                        errors++;
                        $display("[FAIL] tx_payload expected %h got %h", exp_beat, tx_payload);
                    end
                    if (first_pending) begin
                        led_expect = exp_beat.data[7:0];
                    end
                end
                first_pending = 1'b0;
            end
        end
    end

    initial begin
        int waited;
        waited           = 0;
        rst              = 1'b1;
        rx_hdr           = '0;
        rx_hdr_valid     = 1'b0;
        rx_payload       = '0;
        rx_payload_valid = 1'b0;
        $readmemh("sim/udp_echo_patterns.txt", pat_mem);
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        fork
            drive_headers();
            drive_payloads();
        join

        // Wait for every echoed frame to leave the engine
        while ((exp_hdr_q.size() != 0 || exp_beat_q.size() != 0) && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        assert (exp_hdr_q.size() == 0 && exp_beat_q.size() == 0) else begin
            errors++;
            $display("Timed out with %0d headers and %0d beats still expected",
                     exp_hdr_q.size(), exp_beat_q.size());
        end
        repeat (4) @(negedge clk);
        assert (!tx_hdr_valid && !tx_payload_valid) else begin
            errors++;
            $display("Output still active after the last frame");
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* source/udp_echo_core.sv */
// ------------------------------
// UDP echo engine top level
// Header queue and payload FIFO run side by side and
// the frame merger joins them into echoed frames
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module udp_echo_core #(
    parameter logic [15:0] ECHO_PORT     = echo_config_pkg::DEFAULT_ECHO_PORT,
    parameter logic [31:0] LOCAL_IP      = echo_config_pkg::DEFAULT_LOCAL_IP,
    parameter int          HDR_DEPTH     = echo_config_pkg::DEFAULT_HDR_DEPTH,
    parameter int          PAYLOAD_DEPTH = echo_config_pkg::DEFAULT_PAYLOAD_DEPTH
) (
    input  logic                          clk,
    input  logic                          rst,
    input  net_types_pkg::udp_rx_hdr_t    rx_hdr,
    input  logic                          rx_hdr_valid,
    output logic                          rx_hdr_ready,
    input  net_types_pkg::payload_beat_t  rx_payload,
    input  logic                          rx_payload_valid,
    output logic                          rx_payload_ready,
    output net_types_pkg::udp_tx_hdr_t    tx_hdr,
    output logic                          tx_hdr_valid,
    input  logic                          tx_hdr_ready,
    output net_types_pkg::payload_beat_t  tx_payload,
    output logic                          tx_payload_valid,
    input  logic                          tx_payload_ready,
    output logic [7:0]                    led
);

    // Header queue to merger
    net_types_pkg::udp_tx_hdr_t   q_hdr;
    logic                         q_match;
    logic                         q_valid;
    logic                         q_ready;

    // Payload FIFO to merger
    net_types_pkg::payload_beat_t fifo_beat;
    logic                         fifo_valid;
    logic                         fifo_ready;

    echo_header_queue #(
        .ECHO_PORT (ECHO_PORT),
        .LOCAL_IP  (LOCAL_IP),
        .HDR_DEPTH (HDR_DEPTH)
    ) header_queue (
        .clk          (clk),
        .rst          (rst),
        .rx_hdr       (rx_hdr),
        .rx_hdr_valid (rx_hdr_valid),
        .rx_hdr_ready (rx_hdr_ready),
        .q_hdr        (q_hdr),
        .q_match      (q_match),
        .q_valid      (q_valid),
        .q_ready      (q_ready)
    );

    echo_payload_fifo #(
        .PAYLOAD_DEPTH (PAYLOAD_DEPTH)
    ) payload_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_beat   (rx_payload),
        .in_valid  (rx_payload_valid),
        .in_ready  (rx_payload_ready),
        .out_beat  (fifo_beat),
        .out_valid (fifo_valid),
        .out_ready (fifo_ready)
    );

    echo_frame_merger frame_merger (
        .clk              (clk),
        .rst              (rst),
        .q_hdr            (q_hdr),
        .q_match          (q_match),
        .q_valid          (q_valid),
        .q_ready          (q_ready),
        .fifo_beat        (fifo_beat),
        .fifo_valid       (fifo_valid),
        .fifo_ready       (fifo_ready),
        .tx_hdr           (tx_hdr),
        .tx_hdr_valid     (tx_hdr_valid),
        .tx_hdr_ready     (tx_hdr_ready),
        .tx_payload       (tx_payload),
        .tx_payload_valid (tx_payload_valid),
        .tx_payload_ready (tx_payload_ready),
        .led              (led)
    );

endmodule

`default_nettype wire

/* source/echo_frame_merger.sv */
// ------------------------------
// Frame merger of the UDP echo engine
// Sends each matched header with its payload, drains
// the payload of unmatched frames and shows the first
// payload byte of every echoed frame on the LEDs
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module echo_frame_merger (
    input  logic                          clk,
    input  logic                          rst,
    input  net_types_pkg::udp_tx_hdr_t    q_hdr,
    input  logic                          q_match,
    input  logic                          q_valid,
    output logic                          q_ready,
    input  net_types_pkg::payload_beat_t  fifo_beat,
    input  logic                          fifo_valid,
    output logic                          fifo_ready,
    output net_types_pkg::udp_tx_hdr_t    tx_hdr,
    output logic                          tx_hdr_valid,
    input  logic                          tx_hdr_ready,
    output net_types_pkg::payload_beat_t  tx_payload,
    output logic                          tx_payload_valid,
    input  logic                          tx_payload_ready,
    output logic [7:0]                    led
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_HDR,
        ST_PAYLOAD,
        ST_DRAIN
    } state_t;

    state_t state;
    logic   first_beat;
    logic   tx_beat_xfer;
    logic   drain_xfer;
    logic   frame_done;

    // Header entry stays at the queue head until the frame is done
    assign tx_hdr       = q_hdr;
    assign tx_hdr_valid = (state == ST_HDR);

    assign tx_payload       = fifo_beat;
    assign tx_payload_valid = (state == ST_PAYLOAD) && fifo_valid;

    always_comb begin
        case (state)
            ST_PAYLOAD: fifo_ready = tx_payload_ready;
            ST_DRAIN:   fifo_ready = 1'b1;
            default:    fifo_ready = 1'b0;
        endcase
    end

    assign tx_beat_xfer = tx_payload_valid && tx_payload_ready;
    assign drain_xfer   = (state == ST_DRAIN) && fifo_valid;
    assign frame_done   = (tx_beat_xfer || drain_xfer) && fifo_beat.last;
    assign q_ready      = frame_done;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ST_IDLE;
            first_beat <= 1'b0;
            led        <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (q_valid) begin
                        state <= q_match ? ST_HDR : ST_DRAIN;
                    end
                end
                ST_HDR: begin
                    if (tx_hdr_ready) begin
                        state      <= ST_PAYLOAD;
                        first_beat <= 1'b1;
                    end
                end
                ST_PAYLOAD: begin
                    if (tx_beat_xfer) begin
                        first_beat <= 1'b0;
                    end
                    if (frame_done) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    if (frame_done) begin
                        state <= ST_IDLE;
                    end
                end
            endcase

            // Latch low byte of first echoed beat
            if (tx_beat_xfer && first_beat) begin
                led <= fifo_beat.data[7:0];
            end
        end
    end

endmodule

`default_nettype wire

/* source/echo_payload_fifo.sv */
// ------------------------------
// Payload beat FIFO with a registered output stage
// Knows nothing of frames and can hold several at once
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module echo_payload_fifo #(
    parameter int PAYLOAD_DEPTH = echo_config_pkg::DEFAULT_PAYLOAD_DEPTH
) (
    input  logic                          clk,
    input  logic                          rst,
    input  net_types_pkg::payload_beat_t  in_beat,
    input  logic                          in_valid,
    output logic                          in_ready,
    output net_types_pkg::payload_beat_t  out_beat,
    output logic                          out_valid,
    input  logic                          out_ready
);

    localparam int PTR_W = (PAYLOAD_DEPTH > 1) ? $clog2(PAYLOAD_DEPTH) : 1;
    localparam int CNT_W = $clog2(PAYLOAD_DEPTH + 1);

    net_types_pkg::payload_beat_t mem [PAYLOAD_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             load_out;
    logic             push_mem;
    logic             pop_mem;

    assign in_ready = (count != CNT_W'(PAYLOAD_DEPTH));
    assign push     = in_valid && in_ready;
    // Output stage is free or being emptied this cycle
    assign load_out = !out_valid || out_ready;
    assign pop_mem  = load_out && (count != '0);
    // With an empty buffer the beat goes straight to the output stage
    assign push_mem = push && !(load_out && (count == '0));

    always_ff @(posedge clk) begin
        if (push_mem) begin
            mem[wr_ptr] <= in_beat;
        end
        if (pop_mem) begin
            out_beat <= mem[rd_ptr];
        end else if (load_out && push) begin
            out_beat <= in_beat;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            out_valid <= 1'b0;
        end else begin
            if (load_out) begin
                out_valid <= pop_mem || push;
            end
            if (push_mem) begin
                wr_ptr <= (wr_ptr == PTR_W'(PAYLOAD_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_mem) begin
                rd_ptr <= (rd_ptr == PTR_W'(PAYLOAD_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push_mem && !pop_mem) begin
                count <= count + 1'b1;
            end else if (pop_mem && !push_mem) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* source/echo_header_queue.sv */
// ------------------------------
// Header queue of the UDP echo engine
// Checks each received header against the echo port,
// builds the reply header and queues it with the match bit
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module echo_header_queue #(
    parameter logic [15:0] ECHO_PORT = echo_config_pkg::DEFAULT_ECHO_PORT,
    parameter logic [31:0] LOCAL_IP  = echo_config_pkg::DEFAULT_LOCAL_IP,
    parameter int          HDR_DEPTH = echo_config_pkg::DEFAULT_HDR_DEPTH
) (
    input  logic                        clk,
    input  logic                        rst,
    input  net_types_pkg::udp_rx_hdr_t  rx_hdr,
    input  logic                        rx_hdr_valid,
    output logic                        rx_hdr_ready,
    output net_types_pkg::udp_tx_hdr_t  q_hdr,
    output logic                        q_match,
    output logic                        q_valid,
    input  logic                        q_ready
);

    localparam int PTR_W = (HDR_DEPTH > 1) ? $clog2(HDR_DEPTH) : 1;
    localparam int CNT_W = $clog2(HDR_DEPTH + 1);

    typedef struct packed {
        net_types_pkg::udp_tx_hdr_t hdr;
        logic                       match;
    } hdr_entry_t;

    hdr_entry_t       mem [HDR_DEPTH];
    hdr_entry_t       new_entry;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    // Reply goes back to the sender with ports swapped
    always_comb begin
        new_entry.hdr.source_ip   = LOCAL_IP;
        new_entry.hdr.dest_ip     = rx_hdr.source_ip;
        new_entry.hdr.source_port = rx_hdr.dest_port;
        new_entry.hdr.dest_port   = rx_hdr.source_port;
        new_entry.hdr.length      = rx_hdr.length;
        new_entry.hdr.ttl         = echo_config_pkg::REPLY_TTL;
        new_entry.hdr.checksum    = '0;
        new_entry.match           = (rx_hdr.dest_port == ECHO_PORT);
    end

    assign rx_hdr_ready = (count != CNT_W'(HDR_DEPTH));
    assign push         = rx_hdr_valid && rx_hdr_ready;
    assign q_valid      = (count != '0);
    assign pop          = q_valid && q_ready;
    assign q_hdr        = mem[rd_ptr].hdr;
    assign q_match      = mem[rd_ptr].match;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= new_entry;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(HDR_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(HDR_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* source/echo_config_pkg.sv */
// ------------------------------
// Default settings of the UDP echo engine
// The top level takes its parameter defaults from here
// ------------------------------
`default_nettype none

package echo_config_pkg;

    // Port that gets echoed back
    localparam logic [15:0] DEFAULT_ECHO_PORT = 16'd1234;

    // 192.168.1.128
    localparam logic [31:0] DEFAULT_LOCAL_IP = {8'd192, 8'd168, 8'd1, 8'd128};

    // Fixed TTL of every reply
    localparam logic [7:0] REPLY_TTL = 8'd64;

    localparam int DEFAULT_HDR_DEPTH     = 4;
    localparam int DEFAULT_PAYLOAD_DEPTH = 64;

endpackage

`default_nettype wire

/* source/net_types_pkg.sv */
// ------------------------------
// Packet types for the UDP echo engine
// Shared by the RTL and the testbench for the
// payload beats and the UDP header records
// ------------------------------
`default_nettype none

package net_types_pkg;

    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;

    // One 64-bit payload beat, byte 0 in data[7:0]
    typedef struct packed {
        logic [63:0] data;
        logic [7:0]  keep;
        logic        last;
        logic        user;
    } payload_beat_t;

    // Received header fields used by the echo
    typedef struct packed {
        ip_addr_t    source_ip;
        ip_addr_t    dest_ip;
        udp_port_t   source_port;
        udp_port_t   dest_port;
        logic [15:0] length;
    } udp_rx_hdr_t;

    // Reply header handed to the transmit side
    typedef struct packed {
        ip_addr_t    source_ip;
        ip_addr_t    dest_ip;
        udp_port_t   source_port;
        udp_port_t   dest_port;
        logic [15:0] length;
        logic [7:0]  ttl;
        logic [15:0] checksum;
    } udp_tx_hdr_t;

endpackage

`default_nettype wire
